// ==== dv/exec_cluster_checker.sv ====
/*
 * Bound assertions for the execution cluster
 *   Issue strobes only reach a class with a free lane
 *   Each lane sits on at most one bus, and only while done
 *   Failure count watched by the testbench
 */
`timescale 1ns/1ps

module exec_cluster_checker #(
    parameter int FU_NUM  = 4,
    parameter int CDB_NUM = 2
) (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             issue_valid_i,
    input  exec_pkg::opcode_e                issue_op_i,
    input  logic                             alu_free_i,
    input  logic                             mul_free_i,
    input  logic [FU_NUM-1:0]                done_i,
    input  logic [FU_NUM-1:0]                granted_i,
    input  logic [CDB_NUM-1:0][FU_NUM-1:0]   sel_i
);

    // Lanes claimed by more than one bus
    logic [FU_NUM-1:0] overlap;

    // Assertion failures so far
    int fail_cnt = 0;

    always_comb begin
        overlap = '0;
        for (int k = 0; k < CDB_NUM; k++) begin
            for (int j = k + 1; j < CDB_NUM; j++) begin
                overlap = overlap | (sel_i[k] & sel_i[j]);
            end
        end
    end

    // No back-pressure, so the issuer must respect the free flags
    issue_class_free: assert property (@(posedge clk_i) disable iff (rst_i)
        issue_valid_i |-> (exec_pkg::is_mul_op(issue_op_i) ? mul_free_i : alu_free_i))
        else begin
            $error("issue strobe for a class with no free lane");
            fail_cnt++;
        end

    lane_single_bus: assert property (@(posedge clk_i) disable iff (rst_i)
        overlap == '0)
        else begin
            $error("lane granted to more than one bus");
            fail_cnt++;
        end

    grant_needs_done: assert property (@(posedge clk_i) disable iff (rst_i)
        (granted_i & ~done_i) == '0)
        else begin
            $error("grant to a lane without a result");
            fail_cnt++;
        end

endmodule

// Issue side, bus inputs tied idle
bind issue_decode exec_cluster_checker #(.FU_NUM(ALU_NUM + MUL_NUM)) u_chk_issue (
    .clk_i(clk_i), .rst_i(rst_i),
    .issue_valid_i(issue_valid_i), .issue_op_i(issue_op_i),
    .alu_free_i(alu_free_o), .mul_free_i(mul_free_o),
    .done_i('0), .granted_i('0), .sel_i('0)
);

// Bus side, issue inputs tied idle
bind cdb_broadcaster exec_cluster_checker #(
    .FU_NUM(ALU_NUM + MUL_NUM), .CDB_NUM(CDB_NUM)
) u_chk_cdb (
    .clk_i(clk_i), .rst_i(rst_i),
    .issue_valid_i(1'b0), .issue_op_i(exec_pkg::OP_ADD),
    .alu_free_i(1'b1), .mul_free_i(1'b1),
    .done_i(done_i), .granted_i(granted_o), .sel_i(sel_oh)
);

// ==== dv/tb_exec_cluster.sv ====
/*
 * Execution cluster testbench
 *   Clock, reset and CDB monitor with per-ROB bookkeeping
 *   Reference model, check task and directed tests
 */
`timescale 1ns/1ps

module tb_exec_cluster;

    localparam int ALU_NUM = 2;
    localparam int MUL_NUM = 2;
    localparam int CDB_NUM = 2;
    // Cycles allowed for any single wait
    localparam int TIMEOUT = 200;

    logic                                 clk_i;
    logic                                 rst_i;
    logic                                 issue_valid;
    exec_pkg::opcode_e                    issue_op;
    exec_pkg::data_t                      issue_a;
    exec_pkg::data_t                      issue_b;
    exec_pkg::tag_t                       issue_tag;
    exec_pkg::rob_idx_t                   issue_rob;
    logic                                 alu_free;
    logic                                 mul_free;
    logic               [CDB_NUM-1:0]     cdb_valid;
    exec_pkg::tag_t     [CDB_NUM-1:0]     cdb_tag;
    exec_pkg::rob_idx_t [CDB_NUM-1:0]     cdb_rob;
    exec_pkg::data_t    [CDB_NUM-1:0]     cdb_data;
    exec_pkg::tag_t                       prf_raddr;
    exec_pkg::data_t                      prf_rdata;

    // Per-ROB bookkeeping
    logic            pending [32];
    int              issue_cycle [32];
    int              comp_cycle [32];
    exec_pkg::data_t exp_val [32];
    exec_pkg::tag_t  exp_tag [32];
    // Expected register file contents
    exec_pkg::data_t shadow [64];
    int              cycle_cnt;
    string           cur_test;

    exec_cluster_top #(.ALU_NUM(ALU_NUM), .MUL_NUM(MUL_NUM), .CDB_NUM(CDB_NUM)) dut0 (
        .clk_i(clk_i), .rst_i(rst_i),
        .issue_valid_i(issue_valid), .issue_op_i(issue_op),
        .issue_a_i(issue_a), .issue_b_i(issue_b),
        .issue_tag_i(issue_tag), .issue_rob_i(issue_rob),
        .alu_free_o(alu_free), .mul_free_o(mul_free),
        .cdb_valid_o(cdb_valid), .cdb_tag_o(cdb_tag),
        .cdb_rob_o(cdb_rob), .cdb_data_o(cdb_data),
        .prf_raddr_i(prf_raddr), .prf_rdata_o(prf_rdata)
    );

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

    // ====================
    // Check helpers
    // ====================
    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input string what, input logic [63:0] expected,
                            input logic [63:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("** Error [%s] %s: expected 0x%0h, actual 0x%0h",
                                cur_test, what, expected, actual));
        end
    endtask

    // Bound assertion checkers, half a cycle after their clock edge
    always @(negedge clk_i) begin
        if (dut0.u_decode.u_chk_issue.fail_cnt + dut0.u_bc.u_chk_cdb.fail_cnt != 0) begin
            abort_run("A bound assertion in the execution cluster failed");
        end
    end

    // Reference results from the opcode definitions
    function automatic exec_pkg::data_t model_result(input exec_pkg::opcode_e op,
                                                     input exec_pkg::data_t a,
                                                     input exec_pkg::data_t b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        case (op)
            exec_pkg::OP_ADD: return a + b;
            exec_pkg::OP_SUB: return a - b;
            exec_pkg::OP_AND: return a & b;
            exec_pkg::OP_OR:  return a | b;
            exec_pkg::OP_XOR: return a ^ b;
            exec_pkg::OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::OP_MUL: return prod[31:0];
            default:          return '0;
        endcase
    endfunction

    // ====================
    // CDB monitor
    // ====================
    // Registered outputs, sampled mid-cycle
    always @(negedge clk_i) begin : cdb_monitor
        int r;
        if (!rst_i) begin
            for (int k = 0; k < CDB_NUM; k++) begin
                if (cdb_valid[k]) begin
                    r = cdb_rob[k];
                    if (!pending[r]) begin
                        abort_run($sformatf("Result for ROB %0d was not outstanding", r));
                    end
                    check_eq("bus value", exp_val[r], cdb_data[k]);
                    check_eq("bus tag", exp_tag[r], cdb_tag[k]);
                    pending[r]    = 1'b0;
                    comp_cycle[r] = cycle_cnt;
                end
            end
        end
    end

    // ====================
    // Stimulus helpers
    // ====================
    // Waits for a retired ROB slot and a free lane, then strobes on the falling edge
    task automatic send_op(input exec_pkg::opcode_e op, input exec_pkg::data_t a,
                           input exec_pkg::data_t b, input exec_pkg::tag_t tag,
                           input exec_pkg::rob_idx_t rob);
        int   waited;
        logic placed;
        logic slot_ok;
        waited = 0;
        placed = 1'b0;
        while (!placed) begin
            @(posedge clk_i);
            slot_ok = !pending[rob];
            @(negedge clk_i);
            if (slot_ok && (exec_pkg::is_mul_op(op) ? mul_free : alu_free)) begin
                issue_valid      = 1'b1;
                issue_op         = op;
                issue_a          = a;
                issue_b          = b;
                issue_tag        = tag;
                issue_rob        = rob;
                pending[rob]     = 1'b1;
                exp_val[rob]     = model_result(op, a, b);
                exp_tag[rob]     = tag;
                issue_cycle[rob] = cycle_cnt;
                shadow[tag]      = exp_val[rob];
                placed           = 1'b1;
            end else begin
                issue_valid = 1'b0;
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run($sformatf("Timeout waiting to issue ROB %0d", rob));
                end
            end
        end
    endtask

    task automatic end_issue();
        @(negedge clk_i);
        issue_valid = 1'b0;
    endtask

    task automatic wait_retired(input exec_pkg::rob_idx_t rob);
        int waited;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run($sformatf("Timeout waiting for ROB %0d to complete", rob));
            end
        end while (pending[rob]);
    endtask

    task automatic wait_drained();
        int   waited;
        logic busy;
        waited = 0;
        do begin
            @(posedge clk_i);
            busy = 1'b0;
            for (int r = 0; r < 32; r++) begin
                busy = busy | pending[r];
            end
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("Timeout waiting for outstanding results to drain");
            end
        end while (busy);
    endtask

    task automatic read_reg(input exec_pkg::tag_t tag, output exec_pkg::data_t value);
        @(negedge clk_i);
        prf_raddr = tag;
        #10;
        value = prf_rdata;
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic test_reset();
        exec_pkg::data_t v;
        cur_test = "reset";
        @(negedge clk_i);
        check_eq("alu_free_o", 1, alu_free);
        check_eq("mul_free_o", 1, mul_free);
        check_eq("cdb_valid_o", 0, cdb_valid);
        for (int t = 0; t < 64; t++) begin
            read_reg(t, v);
            check_eq($sformatf("register %0d", t), 0, v);
        end
    endtask

    // One op at a time, latency fixed with no contention
    task automatic test_single(input logic use_mul, input int count);
        exec_pkg::opcode_e  op;
        exec_pkg::data_t    a;
        exec_pkg::data_t    b;
        exec_pkg::data_t    v;
        exec_pkg::tag_t     tag;
        exec_pkg::rob_idx_t rob;
        cur_test = use_mul ? "mul_single" : "alu_single";
        for (int i = 0; i < count; i++) begin
            op  = use_mul ? exec_pkg::OP_MUL : exec_pkg::opcode_e'(i % 6);
            a   = $urandom;
            b   = $urandom;
            tag = $urandom_range(0, 63);
            rob = i % 32;
            send_op(op, a, b, tag, rob);
            end_issue();
            wait_retired(rob);
            check_eq("latency", use_mul ? 4 : 2, comp_cycle[rob] - issue_cycle[rob]);
            read_reg(tag, v);
            check_eq("register after writeback", model_result(op, a, b), v);
        end
    endtask

    // All lanes filled back to back
    task automatic test_saturation();
        exec_pkg::opcode_e ops [6];
        exec_pkg::data_t   v;
        cur_test = "saturation";
        ops = '{exec_pkg::OP_MUL, exec_pkg::OP_MUL, exec_pkg::OP_ADD,
                exec_pkg::OP_SUB, exec_pkg::OP_XOR, exec_pkg::OP_SLT};
        for (int i = 0; i < 6; i++) begin
            send_op(ops[i], $urandom, $urandom, 40 + i, i);
        end
        end_issue();
        wait_drained();
        for (int i = 0; i < 6; i++) begin
            read_reg(40 + i, v);
            check_eq($sformatf("register %0d", 40 + i), exp_val[i], v);
        end
    endtask

    // Tag low bits follow the ROB slot, so same-tag writes retire in order
    task automatic test_random_stream();
        exec_pkg::data_t v;
        cur_test = "random_stream";
        for (int i = 0; i < 200; i++) begin
            send_op(exec_pkg::opcode_e'($urandom_range(0, 6)), $urandom, $urandom,
                    {1'($urandom_range(0, 1)), 5'(i % 32)}, i % 32);
        end
        end_issue();
        wait_drained();
        for (int t = 0; t < 64; t++) begin
            read_reg(t, v);
            check_eq($sformatf("register %0d", t), shadow[t], v);
        end
    endtask

    initial begin
        void'($urandom(67899));
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        issue_valid = 1'b0;
        issue_op    = exec_pkg::OP_ADD;
        issue_a     = '0;
        issue_b     = '0;
        issue_tag   = '0;
        issue_rob   = '0;
        prf_raddr   = '0;
        cycle_cnt   = 0;
        cur_test    = "init";
        for (int r = 0; r < 32; r++) begin
            pending[r] = 1'b0;
        end
        for (int t = 0; t < 64; t++) begin
            shadow[t] = '0;
        end
        repeat (2) @(negedge clk_i);
        rst_i = 1'b0;

        test_reset();
        test_single(1'b0, 24);
        test_single(1'b1, 8);
        test_saturation();
        test_random_stream();

        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
src/exec_pkg.sv
src/issue_decode.sv
src/alu_lane.sv
src/mul_lane.sv
src/cdb_broadcaster.sv
src/prf_writeback.sv
src/exec_cluster_top.sv
dv/exec_cluster_checker.sv
dv/tb_exec_cluster.sv

// ==== src/alu_lane.sv ====
/*
 * Single-cycle integer ALU lane
 *   Result computed in the dispatch cycle
 *   Hold register keeps tag, ROB index and value until granted
 */
`timescale 1ns/1ps

module alu_lane (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 dispatch_i,
    input  exec_pkg::opcode_e    op_i,
    input  exec_pkg::data_t      a_i,
    input  exec_pkg::data_t      b_i,
    input  exec_pkg::tag_t       tag_i,
    input  exec_pkg::rob_idx_t   rob_i,
    input  logic                 granted_i,
    output logic                 done_o,
    output logic                 busy_o,
    output exec_pkg::tag_t       tag_o,
    output exec_pkg::rob_idx_t   rob_o,
    output exec_pkg::data_t      value_o
);

    // Lane holds a result awaiting broadcast
    logic            full;
    exec_pkg::data_t result;

    // ====================
    // Combinational ALU
    // ====================
    always_comb begin
        case (op_i)
            exec_pkg::OP_ADD: result = a_i + b_i;
            exec_pkg::OP_SUB: result = a_i - b_i;
            exec_pkg::OP_AND: result = a_i & b_i;
            exec_pkg::OP_OR:  result = a_i | b_i;
            exec_pkg::OP_XOR: result = a_i ^ b_i;
            // Signed compare gives 1 or 0
            exec_pkg::OP_SLT: result = {31'd0, $signed(a_i) < $signed(b_i)};
            default:          result = '0;
        endcase
    end

    // ====================
    // Hold register
    // ====================
    // Occupancy flag, set on dispatch and cleared on grant
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            full <= 1'b0;
        end else if (dispatch_i) begin
            full <= 1'b1;
        end else if (granted_i) begin
            full <= 1'b0;
        end
    end

    // Payload captured with the op
    always_ff @(posedge clk_i) begin
        if (dispatch_i) begin
            value_o <= result;
            tag_o   <= tag_i;
            rob_o   <= rob_i;
        end
    end

    // Single-cycle lane, busy exactly while holding
    assign done_o = full;
    assign busy_o = full;

endmodule

// ==== src/cdb_broadcaster.sv ====
/*
 * Common data bus broadcaster
 *   Chained priority pick, one lane per bus, lowest index first
 *   Fairness mask drops served lanes while others still wait
 *   Per-lane grant feedback and AND-OR bus data mux
 */
`timescale 1ns/1ps

module cdb_broadcaster #(
    parameter int ALU_NUM = 2,
    parameter int MUL_NUM = 2,
    parameter int CDB_NUM = 2
) (
    input  logic                                        clk_i,
    input  logic                                        rst_i,
    input  logic               [ALU_NUM+MUL_NUM-1:0]    done_i,
    input  exec_pkg::tag_t     [ALU_NUM+MUL_NUM-1:0]    tag_i,
    input  exec_pkg::rob_idx_t [ALU_NUM+MUL_NUM-1:0]    rob_i,
    input  exec_pkg::data_t    [ALU_NUM+MUL_NUM-1:0]    value_i,
    output logic               [ALU_NUM+MUL_NUM-1:0]    granted_o,
    output logic               [CDB_NUM-1:0]            bus_valid_o,
    output exec_pkg::tag_t     [CDB_NUM-1:0]            bus_tag_o,
    output exec_pkg::rob_idx_t [CDB_NUM-1:0]            bus_rob_o,
    output exec_pkg::data_t    [CDB_NUM-1:0]            bus_data_o
);

    localparam int FU_NUM = ALU_NUM + MUL_NUM;
    localparam logic [FU_NUM-1:0] ONE = {{(FU_NUM-1){1'b0}}, 1'b1};

    logic [FU_NUM-1:0] mask;
    logic              queued;

    // Requests left for each bus, last entry is what nobody took
    logic [CDB_NUM:0][FU_NUM-1:0]   req_chain;
    // One-hot lane selection per bus
    logic [CDB_NUM-1:0][FU_NUM-1:0] sel_oh;

    // ====================
    // Priority chain
    // ====================
    // Only unmasked done lanes compete
    assign req_chain[0] = done_i & mask;

    genvar k;
    generate
        for (k = 0; k < CDB_NUM; k++) begin : gen_bus
            // Lowest request still standing
            assign sel_oh[k]      = req_chain[k] & (~req_chain[k] + ONE);
            assign req_chain[k+1] = req_chain[k] & ~sel_oh[k];
            assign bus_valid_o[k] = |sel_oh[k];

            // AND-OR mux, zero when the bus is idle
            always_comb begin
                bus_tag_o[k]  = '0;
                bus_rob_o[k]  = '0;
                bus_data_o[k] = '0;
                for (int i = 0; i < FU_NUM; i++) begin
                    if (sel_oh[k][i]) begin
                        bus_tag_o[k]  = bus_tag_o[k]  | tag_i[i];
                        bus_rob_o[k]  = bus_rob_o[k]  | rob_i[i];
                        bus_data_o[k] = bus_data_o[k] | value_i[i];
                    end
                end
            end
        end
    endgenerate

    // ====================
    // Grant feedback
    // ====================
    // Lane granted if any bus picked it
    always_comb begin
        granted_o = '0;
        for (int b = 0; b < CDB_NUM; b++) begin
            granted_o = granted_o | sel_oh[b];
        end
    end

    // Requests that found no bus this cycle
    assign queued = |req_chain[CDB_NUM];

    // ====================
    // Fairness mask
    // ====================
    // Served lanes sit out until the queue drains
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mask <= '0;
        end else if (queued) begin
            mask <= mask & ~granted_o;
        end else begin
            mask <= '1;
        end
    end

endmodule

// ==== src/exec_cluster_top.sv ====
/*
 * Execution cluster top level
 *   Issue decode, ALU and multiplier lanes
 *   CDB broadcaster and register file writeback
 */
`timescale 1ns/1ps

module exec_cluster_top #(
    parameter int ALU_NUM = 2,
    parameter int MUL_NUM = 2,
    parameter int CDB_NUM = 2
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic                                  issue_valid_i,
    input  exec_pkg::opcode_e                     issue_op_i,
    input  exec_pkg::data_t                       issue_a_i,
    input  exec_pkg::data_t                       issue_b_i,
    input  exec_pkg::tag_t                        issue_tag_i,
    input  exec_pkg::rob_idx_t                    issue_rob_i,
    output logic                                  alu_free_o,
    output logic                                  mul_free_o,
    output logic               [CDB_NUM-1:0]      cdb_valid_o,
    output exec_pkg::tag_t     [CDB_NUM-1:0]      cdb_tag_o,
    output exec_pkg::rob_idx_t [CDB_NUM-1:0]      cdb_rob_o,
    output exec_pkg::data_t    [CDB_NUM-1:0]      cdb_data_o,
    input  exec_pkg::tag_t                        prf_raddr_i,
    output exec_pkg::data_t                       prf_rdata_o
);

    localparam int FU_NUM = ALU_NUM + MUL_NUM;

    // Lane handshake wires
    logic               [FU_NUM-1:0]  dispatch;
    logic               [FU_NUM-1:0]  busy;
    logic               [FU_NUM-1:0]  done;
    logic               [FU_NUM-1:0]  granted;
    exec_pkg::tag_t     [FU_NUM-1:0]  fu_tag;
    exec_pkg::rob_idx_t [FU_NUM-1:0]  fu_rob;
    exec_pkg::data_t    [FU_NUM-1:0]  fu_value;

    // Broadcaster to writeback
    logic               [CDB_NUM-1:0] bus_valid;
    exec_pkg::tag_t     [CDB_NUM-1:0] bus_tag;
    exec_pkg::rob_idx_t [CDB_NUM-1:0] bus_rob;
    exec_pkg::data_t    [CDB_NUM-1:0] bus_data;

    issue_decode #(.ALU_NUM(ALU_NUM), .MUL_NUM(MUL_NUM)) u_decode (
        .clk_i(clk_i), .rst_i(rst_i),
        .issue_valid_i(issue_valid_i), .issue_op_i(issue_op_i),
        .busy_i(busy), .dispatch_o(dispatch),
        .alu_free_o(alu_free_o), .mul_free_o(mul_free_o)
    );

    // ALU lanes at indices 0 .. ALU_NUM-1
    genvar i;
    generate
        for (i = 0; i < ALU_NUM; i++) begin : gen_alu
            alu_lane u_alu (
                .clk_i(clk_i), .rst_i(rst_i), .dispatch_i(dispatch[i]),
                .op_i(issue_op_i), .a_i(issue_a_i), .b_i(issue_b_i),
                .tag_i(issue_tag_i), .rob_i(issue_rob_i), .granted_i(granted[i]),
                .done_o(done[i]), .busy_o(busy[i]),
                .tag_o(fu_tag[i]), .rob_o(fu_rob[i]), .value_o(fu_value[i])
            );
        end
        // Multiplier lanes follow the ALUs
        for (i = ALU_NUM; i < FU_NUM; i++) begin : gen_mul
            mul_lane u_mul (
                .clk_i(clk_i), .rst_i(rst_i), .dispatch_i(dispatch[i]),
                .a_i(issue_a_i), .b_i(issue_b_i),
                .tag_i(issue_tag_i), .rob_i(issue_rob_i), .granted_i(granted[i]),
                .done_o(done[i]), .busy_o(busy[i]),
                .tag_o(fu_tag[i]), .rob_o(fu_rob[i]), .value_o(fu_value[i])
            );
        end
    endgenerate

    cdb_broadcaster #(.ALU_NUM(ALU_NUM), .MUL_NUM(MUL_NUM), .CDB_NUM(CDB_NUM)) u_bc (
        .clk_i(clk_i), .rst_i(rst_i),
        .done_i(done), .tag_i(fu_tag), .rob_i(fu_rob), .value_i(fu_value),
        .granted_o(granted), .bus_valid_o(bus_valid), .bus_tag_o(bus_tag),
        .bus_rob_o(bus_rob), .bus_data_o(bus_data)
    );

    prf_writeback #(.CDB_NUM(CDB_NUM)) u_wb (
        .clk_i(clk_i), .rst_i(rst_i),
        .bus_valid_i(bus_valid), .bus_tag_i(bus_tag),
        .bus_rob_i(bus_rob), .bus_data_i(bus_data),
        .cdb_valid_o(cdb_valid_o), .cdb_tag_o(cdb_tag_o),
        .cdb_rob_o(cdb_rob_o), .cdb_data_o(cdb_data_o),
        .prf_raddr_i(prf_raddr_i), .prf_rdata_o(prf_rdata_o)
    );

endmodule

// ==== src/exec_pkg.sv ====
/*
 * Shared definitions for the execution cluster
 *   data_t, tag_t, rob_idx_t   value, physical register and ROB widths
 *   opcode_e                   micro-op operations
 *   is_mul_op                  lane-class helper
 */
package exec_pkg;

    // Operand and result value
    typedef logic [31:0] data_t;

    // Physical register index, 64 entries
    typedef logic [5:0] tag_t;

    // Reorder-buffer slot carried with each result
    typedef logic [4:0] rob_idx_t;

    // Micro-op operations
    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLT = 3'd5,  // signed compare, 1 or 0
        OP_MUL = 3'd6   // low 32 bits of product
    } opcode_e;

    // Multiplier class check
    function automatic logic is_mul_op(input opcode_e op);
        return (op == OP_MUL);
    endfunction

endpackage

// ==== src/issue_decode.sv ====
/*
 * Issue decode
 *   Classifies each issued op as ALU or multiplier class
 *   Picks the lowest idle lane of that class (one-hot dispatch)
 *   Reports per-class free flags back to the issuer
 */
`timescale 1ns/1ps

module issue_decode #(
    parameter int ALU_NUM = 2,
    parameter int MUL_NUM = 2
) (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         issue_valid_i,
    input  exec_pkg::opcode_e            issue_op_i,
    input  logic [ALU_NUM+MUL_NUM-1:0]   busy_i,
    output logic [ALU_NUM+MUL_NUM-1:0]   dispatch_o,
    output logic                         alu_free_o,
    output logic                         mul_free_o
);

    localparam int FU_NUM = ALU_NUM + MUL_NUM;

    // ALU lanes sit at the bottom, multipliers above them
    localparam logic [FU_NUM-1:0] ALU_MASK = {{MUL_NUM{1'b0}}, {ALU_NUM{1'b1}}};
    localparam logic [FU_NUM-1:0] ONE      = {{(FU_NUM-1){1'b0}}, 1'b1};

    logic              is_mul;
    logic [FU_NUM-1:0] idle;
    logic [FU_NUM-1:0] cand;
    logic [FU_NUM-1:0] pick;

    // ====================
    // Classification
    // ====================
    assign is_mul = exec_pkg::is_mul_op(issue_op_i);
    assign idle   = ~busy_i;

    // Idle lanes of the op's class
    assign cand = idle & (is_mul ? ~ALU_MASK : ALU_MASK);

    // Lowest set bit wins
    assign pick = cand & (~cand + ONE);

    // Strobe only during a valid issue cycle
    assign dispatch_o = issue_valid_i ? pick : '0;

    // ====================
    // Per-class free flags
    // ====================
    // Any idle lane in the class is enough
    assign alu_free_o = |(idle & ALU_MASK);
    assign mul_free_o = |(idle & ~ALU_MASK);

endmodule

// ==== src/mul_lane.sv ====
/*
 * Three-stage multiplier lane
 *   Stage 1 registers operands, stage 2 partial products
 *   Stage 3 sums the 64-bit product into the hold register
 *   Busy from dispatch until the result is granted
 */
`timescale 1ns/1ps

module mul_lane (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 dispatch_i,
    input  exec_pkg::data_t      a_i,
    input  exec_pkg::data_t      b_i,
    input  exec_pkg::tag_t       tag_i,
    input  exec_pkg::rob_idx_t   rob_i,
    input  logic                 granted_i,
    output logic                 done_o,
    output logic                 busy_o,
    output exec_pkg::tag_t       tag_o,
    output exec_pkg::rob_idx_t   rob_o,
    output exec_pkg::data_t      value_o
);

    // Stage valid flags
    logic s1_vld;
    logic s2_vld;
    logic full;

    // Stage 1 payload
    exec_pkg::data_t    s1_a;
    exec_pkg::data_t    s1_b;
    exec_pkg::tag_t     s1_tag;
    exec_pkg::rob_idx_t s1_rob;

    // Stage 2 payload, 32x16 partial products
    logic [47:0]        s2_pp_lo;
    logic [47:0]        s2_pp_hi;
    exec_pkg::tag_t     s2_tag;
    exec_pkg::rob_idx_t s2_rob;

    // Full product before truncation
    logic [63:0] product;

    // ====================
    // Pipeline control
    // ====================
    // One op per lane, no overlap within the pipe
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_vld <= 1'b0;
            s2_vld <= 1'b0;
            full   <= 1'b0;
        end else begin
            s1_vld <= dispatch_i;
            s2_vld <= s1_vld;
            if (s2_vld) begin
                full <= 1'b1;
            end else if (granted_i) begin
                full <= 1'b0;
            end
        end
    end

    // ====================
    // Datapath
    // ====================
    always_ff @(posedge clk_i) begin
        if (dispatch_i) begin
            s1_a   <= a_i;
            s1_b   <= b_i;
            s1_tag <= tag_i;
            s1_rob <= rob_i;
        end
        if (s1_vld) begin
            // Split multiplier operand into halves
            s2_pp_lo <= s1_a * s1_b[15:0];
            s2_pp_hi <= s1_a * s1_b[31:16];
            s2_tag   <= s1_tag;
            s2_rob   <= s1_rob;
        end
        if (s2_vld) begin
            value_o <= product[31:0];
            tag_o   <= s2_tag;
            rob_o   <= s2_rob;
        end
    end

    // Recombine partial products
    assign product = {16'd0, s2_pp_lo} + {s2_pp_hi, 16'd0};

    assign done_o = full;
    // Occupied anywhere in the pipe
    assign busy_o = s1_vld | s2_vld | full;

endmodule

// ==== src/prf_writeback.sv ====
/*
 * Writeback stage
 *   Registers the bus outputs onto the cluster CDB ports
 *   Writes the 64-entry physical register file from each valid bus
 *   Combinational read port for consumers
 */
`timescale 1ns/1ps

module prf_writeback #(
    parameter int CDB_NUM = 2
) (
    input  logic                                  clk_i,
    input  logic                                  rst_i,
    input  logic               [CDB_NUM-1:0]      bus_valid_i,
    input  exec_pkg::tag_t     [CDB_NUM-1:0]      bus_tag_i,
    input  exec_pkg::rob_idx_t [CDB_NUM-1:0]      bus_rob_i,
    input  exec_pkg::data_t    [CDB_NUM-1:0]      bus_data_i,
    output logic               [CDB_NUM-1:0]      cdb_valid_o,
    output exec_pkg::tag_t     [CDB_NUM-1:0]      cdb_tag_o,
    output exec_pkg::rob_idx_t [CDB_NUM-1:0]      cdb_rob_o,
    output exec_pkg::data_t    [CDB_NUM-1:0]      cdb_data_o,
    input  exec_pkg::tag_t                        prf_raddr_i,
    output exec_pkg::data_t                       prf_rdata_o
);

    // One entry per tag value
    localparam int PRF_DEPTH = 2 ** $bits(exec_pkg::tag_t);

    exec_pkg::data_t prf [PRF_DEPTH];

    // ====================
    // CDB output registers
    // ====================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cdb_valid_o <= '0;
        end else begin
            cdb_valid_o <= bus_valid_i;
        end
    end

    // Payload follows the bus unconditionally
    always_ff @(posedge clk_i) begin
        cdb_tag_o  <= bus_tag_i;
        cdb_rob_o  <= bus_rob_i;
        cdb_data_o <= bus_data_i;
    end

    // ====================
    // Register file
    // ====================
    // Ascending loop, so the higher bus wins on a tag clash
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int e = 0; e < PRF_DEPTH; e++) begin
                prf[e] <= '0;
            end
        end else begin
            for (int b = 0; b < CDB_NUM; b++) begin
                if (cdb_valid_o[b]) begin
                    prf[cdb_tag_o[b]] <= cdb_data_o[b];
                end
            end
        end
    end

    // Read port, no bypass from the write in flight
    assign prf_rdata_o = prf[prf_raddr_i];

endmodule
